//--- src/fir_config.svh
`ifndef FIR_CONFIG_SVH
`define FIR_CONFIG_SVH

`define FIR_DATA_W       32       // sample, coefficient and result width
`define FIR_ADDR_W       12       // AXI4-Lite address width
`define FIR_NUM_TAPS     11
`define FIR_TAP_IDX_W    4        // wide enough for a tap or history index

// register map
`define FIR_REG_CTRL     12'h000  // bit 0 ap_start, bit 1 ap_done, bit 2 ap_idle
`define FIR_REG_LEN      12'h010  // samples per run
`define FIR_REG_TAP_BASE 12'h080  // tap i at base + 4*i

`endif

//--- src/fir_pkg.sv
`include "fir_config.svh"

package fir_pkg;

    // one sample, coefficient or result
    typedef logic signed [`FIR_DATA_W-1:0] data_t;

    // index into the taps or the sample history
    typedef logic [`FIR_TAP_IDX_W-1:0] tap_idx_t;

    typedef logic [`FIR_ADDR_W-1:0] axil_addr_t;

    // sample count of one run, same width as the LEN register
    typedef logic [`FIR_DATA_W-1:0] run_len_t;

endpackage

//--- src/sample_if.sv
`include "fir_config.svh"

interface sample_if import fir_pkg::*; ();

    logic     job_valid;   // a stored sample waits for the MAC
    logic     job_last;    // that sample closes the run
    logic     job_ready;   // MAC is free
    tap_idx_t rd_idx;      // 0 is the newest sample of the job
    data_t    rd_sample;   // combinational from rd_idx

    modport history (
        output job_valid, job_last, rd_sample,
        input  job_ready, rd_idx
    );

    modport mac (
        input  job_valid, job_last, rd_sample,
        output job_ready, rd_idx
    );

endinterface

//--- src/axil_regs.sv
`include "fir_config.svh"

module axil_regs import fir_pkg::*; (
    input  logic       axis_clk,
    input  logic       axis_rst_n,
    input  logic       awvalid,
    input  logic       wvalid,
    input  logic       bready,
    input  logic       arvalid,
    input  logic       rready,
    input  axil_addr_t awaddr,
    input  axil_addr_t araddr,
    input  data_t      wdata,
    output logic       awready,
    output logic       wready,
    output logic       bvalid,
    output logic       arready,
    output logic       rvalid,
    output logic [1:0] bresp,
    output logic [1:0] rresp,
    output data_t      rdata,
    input  tap_idx_t   coef_idx,
    output data_t      coef,
    output logic       run_start,
    output run_len_t   run_len,
    input  logic       run_done
);

    data_t      coef_mem [`FIR_NUM_TAPS];
    logic       ap_start;
    logic       ap_done;
    logic       ap_idle;
    logic       wr_hs;
    logic       rd_hs;
    logic       start_req;
    axil_addr_t wr_off;
    axil_addr_t rd_off;
    tap_idx_t   wr_tap;
    tap_idx_t   rd_tap;
    logic       wr_is_tap;
    logic       rd_is_tap;
    data_t      rd_word;

    assign wr_hs = awready && awvalid && wvalid;  // awready and wready move together
    assign rd_hs = arready && arvalid;

    // offsets below the tap base wrap to large values and fail the range test
    assign wr_off    = awaddr - `FIR_REG_TAP_BASE;
    assign rd_off    = araddr - `FIR_REG_TAP_BASE;
    assign wr_tap    = wr_off[`FIR_TAP_IDX_W+1:2];
    assign rd_tap    = rd_off[`FIR_TAP_IDX_W+1:2];
    assign wr_is_tap = wr_off < 4 * `FIR_NUM_TAPS;
    assign rd_is_tap = rd_off < 4 * `FIR_NUM_TAPS;

    assign start_req = wr_hs && (awaddr == `FIR_REG_CTRL) && wdata[0] && ap_idle;

    assign wready    = awready;
    assign bresp     = 2'b00;  // always OKAY
    assign rresp     = 2'b00;
    assign run_start = ap_start;  // ap_start lives for a single cycle
    assign coef      = (coef_idx < `FIR_NUM_TAPS) ? coef_mem[coef_idx] : '0;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;
            arready <= arvalid && !arready && !rvalid;
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_start <= 1'b0;
            ap_done  <= 1'b0;
            ap_idle  <= 1'b1;
            run_len  <= '0;
        end else begin
            ap_start <= 1'b0;
            if (start_req) begin
                ap_start <= 1'b1;
                ap_idle  <= 1'b0;
                ap_done  <= 1'b0;
            end else if (run_done) begin
                ap_done <= 1'b1;  // wins over a clearing read in the same cycle
                ap_idle <= 1'b1;
            end else if (rd_hs && (araddr == `FIR_REG_CTRL)) begin
                ap_done <= 1'b0;  // clear on read
            end
            if (wr_hs && (awaddr == `FIR_REG_LEN)) begin
                run_len <= wdata;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (wr_hs && wr_is_tap && ap_idle) begin
            coef_mem[wr_tap] <= wdata;  // taps are frozen during a run
        end
    end

    always_comb begin
        rd_word = '0;
        if (araddr == `FIR_REG_CTRL) begin
            rd_word = {{(`FIR_DATA_W-3){1'b0}}, ap_idle, ap_done, ap_start};
        end else if (araddr == `FIR_REG_LEN) begin
            rd_word = run_len;
        end else if (rd_is_tap) begin
            rd_word = coef_mem[rd_tap];
        end
    end

    always_ff @(posedge axis_clk) begin
        if (rd_hs) begin
            rdata <= rd_word;
        end
    end

    rdata_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

//--- src/sample_history.sv
`include "fir_config.svh"

module sample_history import fir_pkg::*; (
    input  logic     axis_clk,
    input  logic     axis_rst_n,
    input  logic     ss_tvalid,
    input  data_t    ss_tdata,
    output logic     ss_tready,
    input  logic     run_start,
    input  run_len_t run_len,
    sample_if.history hist
);

    data_t    hist_mem [`FIR_NUM_TAPS];
    tap_idx_t wr_ptr;      // slot of the oldest sample, overwritten next
    tap_idx_t newest;
    tap_idx_t rd_base;     // newest sample of the job in the MAC
    tap_idx_t rd_pos;
    run_len_t sample_cnt;
    logic     run_active;
    logic     ss_hs;
    logic     job_hs;
    logic     is_last;

    assign ss_tready = run_active && !hist.job_valid;
    assign ss_hs     = ss_tvalid && ss_tready;
    assign job_hs    = hist.job_valid && hist.job_ready;
    assign is_last   = (sample_cnt + 1'b1) == run_len;
    assign newest    = (wr_ptr == '0) ? tap_idx_t'(`FIR_NUM_TAPS - 1) : wr_ptr - 1'b1;

    // walk back from the job's newest sample around the ring
    always_comb begin
        if (rd_base >= hist.rd_idx) begin
            rd_pos = rd_base - hist.rd_idx;
        end else begin
            rd_pos = rd_base + tap_idx_t'(`FIR_NUM_TAPS) - hist.rd_idx;
        end
    end

    // the MAC reads oldest first, so a new sample may take that slot during the job
    assign hist.rd_sample = hist_mem[rd_pos];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            run_active     <= 1'b0;
            wr_ptr         <= '0;
            sample_cnt     <= '0;
            rd_base        <= '0;
            hist.job_valid <= 1'b0;
            hist.job_last  <= 1'b0;
        end else begin
            if (run_start) begin
                run_active <= 1'b1;
                wr_ptr     <= '0;
                sample_cnt <= '0;
            end else if (ss_hs) begin
                wr_ptr     <= (wr_ptr == `FIR_NUM_TAPS - 1) ? '0 : wr_ptr + 1'b1;
                sample_cnt <= sample_cnt + 1'b1;
                run_active <= !is_last;  // no more input after the last sample
            end
            if (ss_hs) begin
                hist.job_valid <= 1'b1;
                hist.job_last  <= is_last;
            end else if (job_hs) begin
                hist.job_valid <= 1'b0;
            end
            if (job_hs) begin
                rd_base <= newest;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (run_start) begin
            for (int i = 0; i < `FIR_NUM_TAPS; i++) begin
                hist_mem[i] <= '0;  // zero history before the first sample
            end
        end else if (ss_hs) begin
            hist_mem[wr_ptr] <= ss_tdata;
        end
    end

    job_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        hist.job_valid && !hist.job_ready |=> hist.job_valid && $stable(hist.job_last));

endmodule

//--- src/fir_mac.sv
`include "fir_config.svh"

module fir_mac import fir_pkg::*; (
    input  logic     axis_clk,
    input  logic     axis_rst_n,
    sample_if.mac    hist,
    output tap_idx_t coef_idx,
    input  data_t    coef,
    input  logic     sm_tready,
    output logic     sm_tvalid,
    output logic     sm_tlast,
    output data_t    sm_tdata,
    output logic     run_done
);

    logic     busy;        // stepping through the taps
    tap_idx_t tap_idx;     // counts down from the oldest tap
    data_t    acc;
    data_t    prod;
    logic     acc_last;    // job_last of the job in the MAC
    logic     res_valid;   // finished sum waits for the buffer
    logic     buf_full;
    logic     buf_last;
    data_t    buf_data;
    logic     job_hs;
    logic     buf_load;
    logic     sm_hs;

    assign hist.job_ready = !busy && !res_valid;
    assign job_hs         = hist.job_valid && hist.job_ready;
    assign hist.rd_idx    = tap_idx;
    assign coef_idx       = tap_idx;  // coefficient and sample step together
    assign prod           = coef * hist.rd_sample;  // low 32 bits of the product

    assign buf_load  = res_valid && !buf_full;
    assign sm_hs     = buf_full && sm_tready;
    assign sm_tvalid = buf_full;
    assign sm_tdata  = buf_data;
    assign sm_tlast  = buf_full && buf_last;
    assign run_done  = sm_hs && buf_last;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            busy      <= 1'b0;
            tap_idx   <= '0;
            res_valid <= 1'b0;
        end else begin
            if (job_hs) begin
                busy    <= 1'b1;
                tap_idx <= tap_idx_t'(`FIR_NUM_TAPS - 1);
            end else if (busy) begin
                if (tap_idx == '0) begin
                    busy      <= 1'b0;
                    res_valid <= 1'b1;
                end else begin
                    tap_idx <= tap_idx - 1'b1;
                end
            end
            if (buf_load) begin
                res_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (job_hs) begin
            acc      <= '0;
            acc_last <= hist.job_last;
        end else if (busy) begin
            acc <= acc + prod;  // wraps at 32 bits
        end
    end

    // one-entry output buffer, held against back-pressure
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            buf_full <= 1'b0;
            buf_last <= 1'b0;
        end else if (buf_load) begin
            buf_full <= 1'b1;
            buf_last <= acc_last;
        end else if (sm_hs) begin
            buf_full <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (buf_load) begin
            buf_data <= acc;
        end
    end

    sm_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast));

endmodule

//--- src/fir_top.sv
`include "fir_config.svh"

module fir_top import fir_pkg::*; (
    input  logic       axis_clk,
    input  logic       axis_rst_n,
    input  logic       awvalid,
    output logic       awready,
    input  axil_addr_t awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  data_t      wdata,
    output logic       bvalid,
    input  logic       bready,
    output logic [1:0] bresp,
    input  logic       arvalid,
    output logic       arready,
    input  axil_addr_t araddr,
    output logic       rvalid,
    input  logic       rready,
    output data_t      rdata,
    output logic [1:0] rresp,
    input  logic       ss_tvalid,
    output logic       ss_tready,
    input  data_t      ss_tdata,
    output logic       sm_tvalid,
    input  logic       sm_tready,
    output data_t      sm_tdata,
    output logic       sm_tlast
);

    tap_idx_t coef_idx;
    data_t    coef;
    logic     run_start;
    run_len_t run_len;
    logic     run_done;

    sample_if hist_if ();  // sample history to MAC

    axil_regs regs0 (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .wvalid     (wvalid),
        .bready     (bready),
        .arvalid    (arvalid),
        .rready     (rready),
        .awaddr     (awaddr),
        .araddr     (araddr),
        .wdata      (wdata),
        .awready    (awready),
        .wready     (wready),
        .bvalid     (bvalid),
        .arready    (arready),
        .rvalid     (rvalid),
        .bresp      (bresp),
        .rresp      (rresp),
        .rdata      (rdata),
        .coef_idx   (coef_idx),
        .coef       (coef),
        .run_start  (run_start),
        .run_len    (run_len),
        .run_done   (run_done)
    );

    sample_history hist0 (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .run_start  (run_start),
        .run_len    (run_len),
        .hist       (hist_if.history)
    );

    fir_mac mac0 (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .hist       (hist_if.mac),
        .coef_idx   (coef_idx),
        .coef       (coef),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tlast   (sm_tlast),
        .sm_tdata   (sm_tdata),
        .run_done   (run_done)
    );

endmodule

//--- tb/fir_checker.sv
`include "fir_config.svh"

module fir_checker import fir_pkg::*; (
    input  logic       axis_clk,
    input  logic       axis_rst_n,
    input  logic       awvalid,
    input  logic       awready,
    input  axil_addr_t awaddr,
    input  logic       wvalid,
    input  logic       wready,
    input  data_t      wdata,
    input  logic       bvalid,
    input  logic       bready,
    input  logic [1:0] bresp,
    input  logic       arvalid,
    input  logic       arready,
    input  axil_addr_t araddr,
    input  logic       rvalid,
    input  logic       rready,
    input  data_t      rdata,
    input  logic [1:0] rresp,
    input  logic       sm_tvalid,
    input  logic       sm_tready,
    input  logic       sm_tlast,
    input  data_t      sm_tdata,
    output int         error_count,
    output int         check_count,
    output int         out_count
);

    localparam int DATA_WORDS = 64;

    logic [31:0] file_words [DATA_WORDS];
    data_t       exp_data [DATA_WORDS];   // expected results of all runs in order
    logic        exp_last [DATA_WORDS];
    int          exp_total;
    data_t       tap_shadow [`FIR_NUM_TAPS];
    data_t       len_shadow;
    data_t       rd_expect;               // value due on the pending read
    logic        exp_idle;
    logic        exp_done;

    initial begin
        int idx;
        int len;
        $readmemh("tb/fir_testdata.txt", file_words);
        idx       = 0;
        exp_total = 0;
        while (idx < DATA_WORDS) begin
            len = int'(file_words[idx + `FIR_NUM_TAPS]);
            idx = idx + `FIR_NUM_TAPS + 1;
            for (int k = 0; k < len; k++) begin
                exp_data[exp_total] = file_words[idx + 2 * k + 1];
                exp_last[exp_total] = (k == len - 1);  // tlast on the data_length-th result
                exp_total++;
            end
            idx = idx + 2 * len;
        end
    end

    // tap number of a register address, -1 if not a tap
    function automatic int tap_of(input axil_addr_t addr);
        int off;
        off = int'(addr) - `FIR_REG_TAP_BASE;
        if (off >= 0 && off < 4 * `FIR_NUM_TAPS && off % 4 == 0) begin
            return off / 4;
        end
        return -1;
    endfunction

    function automatic data_t read_expect(input axil_addr_t addr);
        int tap;
        tap = tap_of(addr);
        if (addr == `FIR_REG_CTRL) begin
            return data_t'({exp_idle, exp_done, 1'b0});
        end else if (addr == `FIR_REG_LEN) begin
            return len_shadow;
        end else if (tap >= 0) begin
            return tap_shadow[tap];
        end
        return '0;
    endfunction

    task automatic compare(input string name, input data_t got, input data_t want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    always @(posedge axis_clk) begin : monitor
        int tap;
        if (!axis_rst_n) begin
            error_count = 0;
            check_count = 0;
            out_count   = 0;
            exp_idle    = 1'b1;
            exp_done    = 1'b0;
            len_shadow  = '0;
            rd_expect   = '0;
            for (int i = 0; i < `FIR_NUM_TAPS; i++) begin
                tap_shadow[i] = '0;
            end
        end else begin
            if (rvalid && rready) begin
                compare("rdata", rdata, rd_expect);
                compare("rresp", data_t'(rresp), '0);
            end
            if (arvalid && arready) begin
                rd_expect = read_expect(araddr);
                if (araddr == `FIR_REG_CTRL) begin
                    exp_done = 1'b0;  // done clears when read
                end
            end
            if (bvalid && bready) begin
                compare("bresp", data_t'(bresp), '0);
            end
            if (awvalid && awready && wvalid && wready) begin
                tap = tap_of(awaddr);
                if (awaddr == `FIR_REG_CTRL && wdata[0] && exp_idle) begin
                    exp_idle = 1'b0;
                    exp_done = 1'b0;
                end else if (awaddr == `FIR_REG_LEN) begin
                    len_shadow = wdata;
                end else if (tap >= 0 && exp_idle) begin
                    tap_shadow[tap] = wdata;  // taps only change between runs
                end
            end
            if (sm_tvalid && sm_tready) begin
                if (out_count >= exp_total) begin
                    error_count++;
                    $display("at %0t the filter sent more results than the test data holds",
                             $time);
                end else begin
                    compare("sm_tdata", sm_tdata, exp_data[out_count]);
                    compare("sm_tlast", data_t'(sm_tlast), data_t'(exp_last[out_count]));
                    if (exp_last[out_count]) begin
                        exp_done = 1'b1;
                        exp_idle = 1'b1;
                    end
                end
                out_count++;
            end
        end
    end

endmodule

//--- tb/tb_fir.sv
`include "fir_config.svh"

module tb_fir import fir_pkg::*; ();

    localparam int DATA_WORDS = 64;   // words in the test data file
    localparam int CLK_HALF   = 50;
    localparam int DRIVE_DLY  = 10;   // inputs change this long after the rising edge

    logic        axis_clk;
    logic        axis_rst_n;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    axil_addr_t  awaddr, araddr;
    data_t       wdata, rdata;
    logic [1:0]  bresp, rresp;
    logic        ss_tvalid, ss_tready, sm_tvalid, sm_tready, sm_tlast;
    data_t       ss_tdata, sm_tdata;
    int          error_count, check_count, out_count;
    logic [31:0] file_words [DATA_WORDS];
    logic        bp_on;                // random sm_tready stalls and ss_tvalid gaps
    int          total_samples;
    int          test_num;
    int          errs_before;

    fir_top dut0 (.*);

    fir_checker chk0 (.*);

    initial begin
        axis_clk = 1'b0;
        forever #CLK_HALF axis_clk = ~axis_clk;
    end

    initial begin
        wait (total_samples > 0);
        #((40 * total_samples + 2000) * 2 * CLK_HALF);
        $display("timeout: the run did not finish within %0d cycles",
                 40 * total_samples + 2000);
        $display("TEST FAIL");
        $finish;
    end

    // drives sm_tready in random stretches of high and low
    initial begin
        int stretch;
        stretch   = 0;
        sm_tready = 1'b1;
        forever begin
            @(posedge axis_clk);
            #DRIVE_DLY;
            if (!bp_on) begin
                sm_tready = 1'b1;
            end else if (stretch == 0) begin
                sm_tready = ($urandom % 3) != 0;
                stretch   = 1 + ($urandom % 5);
            end else begin
                stretch = stretch - 1;
            end
        end
    end

    task automatic step_cycle();
        @(posedge axis_clk);
        #DRIVE_DLY;
    endtask

    task automatic axil_write(input axil_addr_t addr, input data_t data);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!awready) step_cycle();
        step_cycle();  // handshake on this edge
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) step_cycle();
        step_cycle();
    endtask

    task automatic axil_read(input axil_addr_t addr);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) step_cycle();
        step_cycle();
        arvalid = 1'b0;
        while (!rvalid) step_cycle();
        step_cycle();  // the checker compares rdata here
    endtask

    task automatic send_sample(input data_t sample);
        if (bp_on) begin
            repeat ($urandom % 4) step_cycle();
        end
        ss_tdata  = sample;
        ss_tvalid = 1'b1;
        while (!ss_tready) step_cycle();
        step_cycle();
        ss_tvalid = 1'b0;
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (error_count == errs_before) begin
            $display("test %0d, %s: ok", test_num, name);
        end else begin
            $display("test %0d, %s: %0d errors", test_num, name, error_count - errs_before);
        end
        errs_before = error_count;
    endtask

    function automatic axil_addr_t tap_addr(input int i);
        return axil_addr_t'(`FIR_REG_TAP_BASE + 4 * i);
    endfunction

    function automatic int count_samples();
        int idx;
        int total;
        idx   = 0;
        total = 0;
        while (idx < DATA_WORDS) begin
            total = total + int'(file_words[idx + `FIR_NUM_TAPS]);
            idx   = idx + `FIR_NUM_TAPS + 1 + 2 * int'(file_words[idx + `FIR_NUM_TAPS]);
        end
        return total;
    endfunction

    initial begin
        int idx;
        int len;
        int run;
        int outputs_due;
        void'($urandom(32'hb677_100f));
        axis_rst_n  = 1'b0;
        awvalid     = 1'b0;
        wvalid      = 1'b0;
        arvalid     = 1'b0;
        bready      = 1'b1;
        rready      = 1'b1;
        awaddr      = '0;
        araddr      = '0;
        wdata       = '0;
        ss_tvalid   = 1'b0;
        ss_tdata    = '0;
        bp_on       = 1'b0;
        test_num    = 0;
        errs_before = 0;
        $readmemh("tb/fir_testdata.txt", file_words);
        total_samples = count_samples();
        repeat (8) @(posedge axis_clk);
        #DRIVE_DLY;
        axis_rst_n = 1'b1;
        step_cycle();

        axil_read(`FIR_REG_CTRL);
        end_test("status after reset");

        idx         = 0;
        run         = 0;
        outputs_due = 0;
        while (idx < DATA_WORDS) begin
            len   = int'(file_words[idx + `FIR_NUM_TAPS]);
            bp_on = (run > 0);  // later runs see stalls and gaps
            for (int i = 0; i < `FIR_NUM_TAPS; i++) begin
                axil_write(tap_addr(i), file_words[idx + i]);
            end
            axil_write(`FIR_REG_LEN, len);
            for (int i = 0; i < `FIR_NUM_TAPS; i++) begin
                axil_read(tap_addr(i));
            end
            axil_read(`FIR_REG_LEN);
            end_test($sformatf("run %0d taps and data_length readback", run + 1));

            axil_write(`FIR_REG_CTRL, 32'd1);
            idx = idx + `FIR_NUM_TAPS + 1;
            for (int k = 0; k < len; k++) begin
                send_sample(file_words[idx + 2 * k]);
            end
            outputs_due = outputs_due + len;
            while (out_count < outputs_due) step_cycle();
            end_test($sformatf("run %0d outputs", run + 1));

            axil_read(`FIR_REG_CTRL);  // done and idle set
            axil_read(`FIR_REG_CTRL);  // done cleared by the first read
            end_test($sformatf("run %0d status after last output", run + 1));
            idx = idx + 2 * len;
            run++;
        end

        $display("tests %0d, checks %0d, errors %0d, outputs %0d of %0d",
                 test_num, check_count, error_count, out_count, total_samples);
        if (error_count == 0 && out_count == total_samples) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+src
src/fir_pkg.sv
src/sample_if.sv
src/axil_regs.sv
src/sample_history.sv
src/fir_mac.sv
src/fir_top.sv
tb/fir_checker.sv
tb/tb_fir.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the FIR testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_fir \
    -Mdir "$build_dir" -o tb_fir -f sources.f
if [ $? -ne 0 ]; then
    echo "error: Verilator build failed"
    exit 1
fi

"./$build_dir/tb_fir" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "error: simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$log"; then
    echo "simulation passed"
    exit 0
fi
echo "error: pass line not found in $log"
exit 1

//--- tb/fir_testdata.txt
// each run: one line of 11 taps (tap 0 first), one line with data_length,
// then data_length lines of: input sample, expected output (32-bit hex)
1 2 3 4 5 6 7 8 9 a b
8
1 1
2 4
3 a
4 14
5 23
6 38
7 54
8 78
2 ffffffff 0 0 0 100 0 0 0 0 3
c
12345678 2468acf0
fffffffb edcba97e
7 13
10000 1fff9
ffffffff fffefffe
64 345678c9
3 fffffaa2
0 6fd
ffffffec ffffd8
9 ffffff26
3e8 369d6f2f
2 ffffff0d
